//--- src/z80_bus_pkg.sv
/* I/O request and port decode types shared by every peer of the port block.
   Only the low address byte selects a port; the high byte is a qualifier. */
`default_nettype none

package z80_bus_pkg;

	// one I/O cycle as the peers see it
	typedef struct packed {
		logic [7:0] loa;  // a[7:0]
		logic [7:0] hoa;  // a[15:8]
		logic [7:0] data; // z80 write data
		logic       rd;   // one-clock read pulse
		logic       wr;   // one-clock write pulse
	} io_req_t;

	typedef struct packed {
		logic fe;
		logic xt;       // xxAF extended registers
		logic fd7ffd;   // any xxFD, a15 checked by the pager
		logic f7eff7;   // xxF7 with the dos-dependent a8
		logic ide_even; // every IDE port routed to the device
		logic ide_10;
		logic ide_11;   // high byte latch, never reaches the device
		logic ide_c8;   // cs1 register
		logic sd_cfg;
		logic sd_dat;
	} port_hit_t;

	localparam logic [7:0] PORT_FE = 8'hFE;
	localparam logic [7:0] PORT_XT = 8'hAF;
	localparam logic [7:0] PORT_FD = 8'hFD;
	localparam logic [7:0] PORT_F7 = 8'hF7;

	localparam logic [7:0] IDE_10 = 8'h10;
	localparam logic [7:0] IDE_11 = 8'h11;
	localparam logic [7:0] IDE_30 = 8'h30;
	localparam logic [7:0] IDE_50 = 8'h50;
	localparam logic [7:0] IDE_70 = 8'h70;
	localparam logic [7:0] IDE_90 = 8'h90;
	localparam logic [7:0] IDE_B0 = 8'hB0;
	localparam logic [7:0] IDE_D0 = 8'hD0;
	localparam logic [7:0] IDE_F0 = 8'hF0;
	localparam logic [7:0] IDE_C8 = 8'hC8;

	localparam logic [7:0] SD_CFG = 8'h77;
	localparam logic [7:0] SD_DAT = 8'h57;

endpackage

`default_nettype wire

//--- src/xt_regs_pkg.sv
/* xxAF register map and reset state of the configuration block.
   Indices are the high address byte of the xxAF cycle. */
`default_nettype none

package xt_regs_pkg;

	localparam logic [7:0] XR_VCONF   = 8'h00;
	localparam logic [7:0] XR_VPAGE   = 8'h01;
	localparam logic [7:0] XR_TSCONF  = 8'h06;
	localparam logic [7:0] XR_PALSEL  = 8'h07;
	localparam logic [7:0] XR_BORDER  = 8'h0F;
	localparam logic [7:0] XR_RAMPAGE = 8'h10; // first of the page windows, 10..13
	localparam logic [7:0] XR_FMADDR  = 8'h15;
	localparam logic [7:0] XR_SYSCONF = 8'h20;
	localparam logic [7:0] XR_MEMCONF = 8'h21;
	localparam logic [7:0] XR_IM2VECT = 8'h25;
	localparam logic [7:0] XR_FDDVIRT = 8'h29;

	localparam logic [7:0] SYSCONF_RST = 8'h01; // 7 MHz turbo
	localparam logic [7:0] MEMCONF_RST = 8'h04; // no map
	localparam logic [7:0] IM2VECT_RST = 8'hFF;

	// page 0 in the low byte: 00, 05, 02, 00
	localparam logic [31:0] RAMPAGE_RST = 32'h00_02_05_00;

	// write strobes for the video block, one clock each
	typedef struct packed {
		logic zborder; // FE write
		logic border;
		logic zvpage;  // accepted 7FFD write
		logic vpage;
		logic vconf;
		logic palsel;
		logic tsconf;
	} video_wr_t;

endpackage

`default_nettype wire

//--- src/io_cycle_decode.sv
/* Strobes come one clock after the first edge that sees iord or iowr high.
   Hits are pure decode of the live address and dos, valid outside I/O cycles too. */
`timescale 1ns/1ns
`default_nettype none

module io_cycle_decode (
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire [15:0]             a,
	input  wire [7:0]              din,
	input  wire                    iord,
	input  wire                    iowr,
	input  wire                    dos,
	output z80_bus_pkg::io_req_t   req,
	output z80_bus_pkg::port_hit_t hit,
	output logic                   porthit,
	output logic                   dataout
);
	import z80_bus_pkg::*;

	logic       iord_reg;
	logic       iowr_reg;
	logic       port_rd;
	logic       port_wr;
	logic [7:0] loa;
	logic [7:0] hoa;

	assign loa = a[7:0];
	assign hoa = a[15:8];

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iord_reg <= 1'b0;
			iowr_reg <= 1'b0;
			port_rd  <= 1'b0;
			port_wr  <= 1'b0;
		end
		else
		begin
			iord_reg <= iord;
			iowr_reg <= iowr;
			port_rd  <= iord && !iord_reg; // rising edge of the level
			port_wr  <= iowr && !iowr_reg;
		end
	end

	always_comb
	begin
		req.loa  = loa;
		req.hoa  = hoa;
		req.data = din;
		req.rd   = port_rd;
		req.wr   = port_wr;
	end

	always_comb
	begin
		hit.fe       = (loa == PORT_FE);
		hit.xt       = (loa == PORT_XT);
		hit.fd7ffd   = (loa == PORT_FD);
		hit.f7eff7   = (loa == PORT_F7) && (hoa[0] ^ dos); // a8=1 normally, a8=0 in dos
		hit.ide_even = loa inside {IDE_10, IDE_30, IDE_50, IDE_70, IDE_90,
			IDE_B0, IDE_D0, IDE_F0, IDE_C8};
		hit.ide_10   = (loa == IDE_10);
		hit.ide_11   = (loa == IDE_11);
		hit.ide_c8   = (loa == IDE_C8);
		// in dos 77 belongs to other hardware, so config moves to 57 with a15 set
		hit.sd_cfg   = ((loa == SD_CFG) && !dos) || ((loa == SD_DAT) && dos && hoa[7]);
		hit.sd_dat   = (loa == SD_DAT);
	end

	assign porthit = |hit;
	assign dataout = porthit && iord; // drive the z80 bus only on our own reads

endmodule

`default_nettype wire

//--- src/xt_config_regs.sv
/* NUM_PAGES must be at least 4: 7FFD loads page 3 and xxAF reads page 2 and 3 back.
   Only the pages at 12 and 13 read back, every other xxAF index reads FF. */
`timescale 1ns/1ns
`default_nettype none

module xt_config_regs #(
	parameter int NUM_PAGES = 4
) (
	input  wire                      zclk,
	input  wire                      rst_n,
	input  wire z80_bus_pkg::io_req_t   req,
	input  wire z80_bus_pkg::port_hit_t hit,
	output logic [NUM_PAGES*8-1:0]   xt_page,
	output logic [4:0]               fmaddr,
	output logic [7:0]               sysconf,
	output logic [7:0]               memconf,
	output logic [7:0]               im2vect,
	output logic [3:0]               fddvirt,
	output logic [7:0]               peff7,
	output logic                     p7ffd_1m_on,
	output logic                     p7ffd_ram0_0,
	output logic                     romrw_en,
	output xt_regs_pkg::video_wr_t   vid_wr,
	output logic [7:0]               rd_data
);
	import xt_regs_pkg::*;

	localparam int PW = (NUM_PAGES > 1) ? $clog2(NUM_PAGES) : 1;

	logic [7:0] rampage [NUM_PAGES];
	logic [7:0] p7ffd;
	logic [7:0] peff7_int;
	logic       fmaddr_hi;
	logic [3:0] fmaddr_lo;
	logic [7:0] page_idx;
	logic       page_sel;
	logic       xt_wr;
	logic       p7ffd_wr;
	logic       peff7_wr;
	logic       lock128;

	assign xt_wr    = hit.xt && req.wr;
	assign p7ffd_wr = hit.fd7ffd && req.wr && !req.hoa[7] && !p7ffd[5]; // bit 5 locks 7FFD
	// the F7 hit already encodes dos in a8, so a8=1 here means outside dos
	assign peff7_wr = hit.f7eff7 && req.wr && req.hoa[0] && !req.hoa[4];
	assign lock128  = (memconf[7:6] == 2'b01);
	assign page_idx = req.hoa - XR_RAMPAGE; // wraps high below 10
	assign page_sel = (page_idx < 8'(NUM_PAGES));

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			fmaddr_hi <= 1'b0;
			sysconf   <= SYSCONF_RST;
			memconf   <= MEMCONF_RST;
			im2vect   <= IM2VECT_RST;
			fddvirt   <= 4'h0;
			for (int i = 0; i < NUM_PAGES; i++)
				rampage[i] <= (i < 4) ? RAMPAGE_RST[(i % 4) * 8 +: 8] : 8'h00;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= req.data[4]; // rom select follows 7FFD
			rampage[3] <= {3'b000, lock128 ? 2'b00 : req.data[7:6], req.data[2:0]};
		end
		else if (xt_wr)
		begin
			if (page_sel)
				rampage[page_idx[PW-1:0]] <= req.data;
			if (req.hoa == XR_FMADDR)
				fmaddr_hi <= req.data[4]; // enable bit
			if (req.hoa == XR_SYSCONF)
				sysconf <= req.data;
			if (req.hoa == XR_MEMCONF)
				memconf <= req.data;
			if (req.hoa == XR_IM2VECT)
				im2vect <= req.data;
			if (req.hoa == XR_FDDVIRT)
				fddvirt <= req.data[3:0];
		end
	end

	always_ff @(posedge zclk)
	begin
		if (xt_wr && (req.hoa == XR_FMADDR))
			fmaddr_lo <= req.data[3:0];
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd     <= 8'h00;
			peff7_int <= 8'h00;
		end
		else
		begin
			if (p7ffd_wr)
				p7ffd <= req.data;
			if (peff7_wr)
				peff7_int <= req.data; // 0 p16c, 2 block1m, 3 ram0, 4 turbo off
		end
	end

	assign fmaddr       = {fmaddr_hi, fmaddr_lo};
	assign peff7        = peff7_int[2] ? (peff7_int & 8'hB1) : peff7_int;
	assign p7ffd_1m_on  = !peff7_int[2];
	assign p7ffd_ram0_0 = peff7_int[3];
	assign romrw_en     = memconf[1];

	always_comb
	begin
		for (int i = 0; i < NUM_PAGES; i++)
			xt_page[i*8 +: 8] = rampage[i];
	end

	always_comb
	begin
		vid_wr.zborder = hit.fe && req.wr;
		vid_wr.border  = xt_wr && (req.hoa == XR_BORDER);
		vid_wr.zvpage  = p7ffd_wr; // screen bit rides on 7FFD
		vid_wr.vpage   = xt_wr && (req.hoa == XR_VPAGE);
		vid_wr.vconf   = xt_wr && (req.hoa == XR_VCONF);
		vid_wr.palsel  = xt_wr && (req.hoa == XR_PALSEL);
		vid_wr.tsconf  = xt_wr && (req.hoa == XR_TSCONF);
	end

	always_comb
	begin
		case (req.hoa)
			XR_RAMPAGE + 8'd2: rd_data = rampage[2];
			XR_RAMPAGE + 8'd3: rd_data = rampage[3];
			default:           rd_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- src/ide_bridge.sv
/* Normal order is 11 then 10 for writes and 10 then 11 for reads; nemo-divide uses 10 twice.
   Port 11 never reaches the device. The Z80 must leave an idle clock between cycles. */
`timescale 1ns/1ns
`default_nettype none

module ide_bridge (
	input  wire                         zclk,
	input  wire                         rst_n,
	input  wire z80_bus_pkg::io_req_t   req,
	input  wire z80_bus_pkg::port_hit_t hit,
	input  wire                         iord,
	input  wire                         iowr,
	input  wire [15:0]                  idein,
	output logic [15:0]                 ideout,
	output logic                        idedataout,
	output logic [2:0]                  ide_a,
	output logic                        ide_cs0_n,
	output logic                        ide_cs1_n,
	output logic                        ide_rd_n,
	output logic                        ide_wr_n,
	output logic [7:0]                  rd_data
);
	logic        ide_any;
	logic        ide_rw;
	logic        ide_rd_trig;  // low byte already read, next 10 read gives the high byte
	logic        ide_wrlo_trig; // low byte held from a divide write
	logic        ide_wrhi_trig; // high byte held from an 11 write
	logic        ide_rd_latch;
	logic        ide_wrlo_latch;
	logic        ide_wrhi_latch;
	logic [15:0] idewrreg;
	logic [7:0]  idehiin;

	assign ide_any = hit.ide_even || hit.ide_11;
	assign ide_rw  = ide_any && (req.rd || req.wr);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			ide_rd_trig   <= 1'b0;
			ide_wrlo_trig <= 1'b0;
			ide_wrhi_trig <= 1'b0;
		end
		else
		begin
			if (hit.ide_10 && req.rd && !ide_rd_trig)
				ide_rd_trig <= 1'b1;
			else if (ide_rw)
				ide_rd_trig <= 1'b0; // any other IDE access ends the pair

			if (ide_rw)
			begin
				ide_wrhi_trig <= hit.ide_11 && req.wr;
				ide_wrlo_trig <= hit.ide_10 && req.wr && !ide_wrhi_trig && !ide_wrlo_trig;
			end
		end
	end

	// triggers change inside a cycle, the latches keep the value seen at its start
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			ide_rd_latch   <= 1'b0;
			ide_wrlo_latch <= 1'b0;
			ide_wrhi_latch <= 1'b0;
		end
		else
		begin
			if (!iord)
				ide_rd_latch <= ide_rd_trig;
			if (!iowr)
			begin
				ide_wrlo_latch <= ide_wrlo_trig;
				ide_wrhi_latch <= ide_wrhi_trig;
			end
		end
	end

	always_ff @(posedge zclk)
	begin
		if (req.wr && hit.ide_11)
			idewrreg[15:8] <= req.data;
		if (req.wr && hit.ide_10 && !ide_wrlo_trig)
			idewrreg[7:0] <= req.data;
		if (req.rd && hit.ide_10 && !ide_rd_trig)
			idehiin <= idein[15:8]; // keep the high half for the second read
	end

	assign ide_a     = req.loa[7:5];
	assign ide_cs0_n = !hit.ide_even || hit.ide_c8;
	assign ide_cs1_n = !hit.ide_even || !hit.ide_c8;

	// second divide read of 10 comes from idehiin, no device cycle
	assign ide_rd_n = !iord || !hit.ide_even || (ide_rd_latch && hit.ide_10);
	// the first byte written to 10 only fills the holding register
	assign ide_wr_n = !iowr || !hit.ide_even ||
		(hit.ide_10 && !ide_wrlo_latch && !ide_wrhi_latch);
	assign idedataout = !ide_wr_n;

	assign ideout[15:8] = ide_wrhi_latch ? idewrreg[15:8] : req.data;
	assign ideout[7:0]  = ide_wrlo_latch ? idewrreg[7:0] : req.data;

	always_comb
	begin
		if (hit.ide_11 || (ide_rd_latch && hit.ide_10))
			rd_data = idehiin;
		else
			rd_data = idein[7:0];
	end

endmodule

`default_nettype wire

//--- src/sd_port.sv
/* Card is always reported present and writable. sd_datain is valid only
   in the clock of the write pulse, which is when the SPI master takes it. */
`timescale 1ns/1ns
`default_nettype none

module sd_port (
	input  wire                         zclk,
	input  wire                         rst_n,
	input  wire z80_bus_pkg::io_req_t   req,
	input  wire z80_bus_pkg::port_hit_t hit,
	output logic                        sdcs_n,
	output logic                        sd_start,
	output logic [7:0]                  sd_datain,
	output logic [7:0]                  rd_data
);
	logic cfg_wr;
	logic dat_wr;
	logic dat_rd;

	assign cfg_wr = hit.sd_cfg && req.wr;
	assign dat_wr = hit.sd_dat && !hit.sd_cfg && req.wr; // 57 with a15 in dos is config
	assign dat_rd = hit.sd_dat && req.rd;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			sdcs_n <= 1'b1; // card deselected
		else if (cfg_wr)
			sdcs_n <= req.data[1];
	end

	assign sd_start  = dat_wr || dat_rd;
	assign sd_datain = req.wr ? req.data : 8'hFF; // FF clocks in the read byte
	assign rd_data   = 8'h00; // config readback

endmodule

`default_nettype wire

//--- src/port_read_mux.sv
/* Read data for the Z80 bus; hits are exclusive except SD at 57 in dos,
   where data wins. Unhandled ports read FF. */
`timescale 1ns/1ns
`default_nettype none

module port_read_mux (
	input  wire z80_bus_pkg::port_hit_t hit,
	input  wire [4:0]                   keys_in,
	input  wire                         tape_read,
	input  wire [7:0]                   sd_dataout,
	input  wire [7:0]                   xt_rd,
	input  wire [7:0]                   ide_rd,
	input  wire [7:0]                   sd_rd,
	output logic [7:0]                  dout
);
	always_comb
	begin
		if (hit.fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (hit.xt)
			dout = xt_rd;
		else if (hit.ide_even || hit.ide_11)
			dout = ide_rd;
		else if (hit.sd_dat)
			dout = sd_dataout; // byte from the last SPI exchange
		else if (hit.sd_cfg)
			dout = sd_rd;
		else
			dout = 8'hFF;
	end

endmodule

`default_nettype wire

//--- src/zports_top.sv
/* iord and iowr are levels held for the whole cycle, at least 3 clocks,
   with an idle clock between cycles. Everything runs on zclk. */
`timescale 1ns/1ns
`default_nettype none

module zports_top #(
	parameter int NUM_PAGES = 4
) (
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire [15:0]             a,
	input  wire [7:0]              din,
	input  wire                    iord,
	input  wire                    iowr,
	input  wire                    dos,
	input  wire [4:0]              keys_in,
	input  wire                    tape_read,
	input  wire [15:0]             idein,
	input  wire [7:0]              sd_dataout,
	output logic [7:0]             dout,
	output logic                   dataout,
	output logic                   porthit,
	output logic [15:0]            ideout,
	output logic                   idedataout,
	output logic [2:0]             ide_a,
	output logic                   ide_cs0_n,
	output logic                   ide_cs1_n,
	output logic                   ide_rd_n,
	output logic                   ide_wr_n,
	output logic [NUM_PAGES*8-1:0] xt_page,
	output logic [4:0]             fmaddr,
	output logic [7:0]             sysconf,
	output logic [7:0]             memconf,
	output logic [7:0]             im2vect,
	output logic [3:0]             fddvirt,
	output logic [7:0]             peff7,
	output logic                   p7ffd_1m_on,
	output logic                   p7ffd_ram0_0,
	output logic                   romrw_en,
	output xt_regs_pkg::video_wr_t vid_wr,
	output logic                   sdcs_n,
	output logic                   sd_start,
	output logic [7:0]             sd_datain
);
	import z80_bus_pkg::*;

	io_req_t    req;
	port_hit_t  hit;
	logic [7:0] xt_rd;
	logic [7:0] ide_rd;
	logic [7:0] sd_rd;

	io_cycle_decode decode_i (
		.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iord(iord), .iowr(iowr), .dos(dos),
		.req(req), .hit(hit), .porthit(porthit), .dataout(dataout)
	);

	xt_config_regs #(.NUM_PAGES(NUM_PAGES)) xt_regs_i (
		.zclk(zclk), .rst_n(rst_n), .req(req), .hit(hit),
		.xt_page(xt_page), .fmaddr(fmaddr), .sysconf(sysconf), .memconf(memconf),
		.im2vect(im2vect), .fddvirt(fddvirt), .peff7(peff7), .p7ffd_1m_on(p7ffd_1m_on),
		.p7ffd_ram0_0(p7ffd_ram0_0), .romrw_en(romrw_en), .vid_wr(vid_wr), .rd_data(xt_rd)
	);

	ide_bridge ide_i (
		.zclk(zclk), .rst_n(rst_n), .req(req), .hit(hit), .iord(iord), .iowr(iowr),
		.idein(idein), .ideout(ideout), .idedataout(idedataout), .ide_a(ide_a),
		.ide_cs0_n(ide_cs0_n), .ide_cs1_n(ide_cs1_n), .ide_rd_n(ide_rd_n),
		.ide_wr_n(ide_wr_n), .rd_data(ide_rd)
	);

	sd_port sd_i (
		.zclk(zclk), .rst_n(rst_n), .req(req), .hit(hit), .sdcs_n(sdcs_n),
		.sd_start(sd_start), .sd_datain(sd_datain), .rd_data(sd_rd)
	);

	port_read_mux rd_mux_i (
		.hit(hit), .keys_in(keys_in), .tape_read(tape_read), .sd_dataout(sd_dataout),
		.xt_rd(xt_rd), .ide_rd(ide_rd), .sd_rd(sd_rd), .dout(dout)
	);

endmodule

`default_nettype wire

//--- tb/tb_zports_model.svh
/* Reference model of the port block state, written from the port rules.
   IDE word order is checked by the testbench sequences directly. */
`ifndef TB_ZPORTS_MODEL_SVH
`define TB_ZPORTS_MODEL_SVH

logic [7:0] m_page [4];
logic [7:0] m_sysconf;
logic [7:0] m_memconf;
logic [7:0] m_im2vect;
logic [3:0] m_fddvirt;
logic       m_fm_hi;
logic [3:0] m_fm_lo;
logic       m_fm_known; // low fmaddr bits have no reset value
logic [7:0] m_p7ffd;
logic [7:0] m_peff7;
logic       m_sdcs_n;

function automatic void model_reset();
	m_page[0] = 8'h00;
	m_page[1] = 8'h05;
	m_page[2] = 8'h02;
	m_page[3] = 8'h00;
	m_sysconf = 8'h01;
	m_memconf = 8'h04;
	m_im2vect = 8'hFF;
	m_fddvirt = 4'h0;
	m_fm_hi = 1'b0;
	m_fm_lo = 4'h0;
	m_fm_known = 1'b0;
	m_p7ffd = 8'h00;
	m_peff7 = 8'h00;
	m_sdcs_n = 1'b1;
endfunction

function automatic void model_write(logic [15:0] addr, logic [7:0] d, logic dv);
	logic [7:0] lo;
	logic [7:0] hi;
	lo = addr[7:0];
	hi = addr[15:8];
	if (lo == 8'hAF)
	begin
		if (hi >= 8'h10 && hi <= 8'h13)
			m_page[hi[1:0]] = d;
		if (hi == 8'h15)
		begin
			m_fm_hi = d[4];
			m_fm_lo = d[3:0];
			m_fm_known = 1'b1;
		end
		if (hi == 8'h20) m_sysconf = d;
		if (hi == 8'h21) m_memconf = d;
		if (hi == 8'h25) m_im2vect = d;
		if (hi == 8'h29) m_fddvirt = d[3:0];
	end
	if (lo == 8'hFD && !hi[7] && !m_p7ffd[5])
	begin
		// lock128 keeps page 3 inside the first 128k
		m_page[3] = {3'b000, (m_memconf[7:6] == 2'b01) ? 2'b00 : d[7:6], d[2:0]};
		m_memconf[0] = d[4];
		m_p7ffd = d;
	end
	if (lo == 8'hF7 && !dv && hi[0] && !hi[4])
		m_peff7 = d;
	if ((lo == 8'h77 && !dv) || (lo == 8'h57 && dv && hi[7]))
		m_sdcs_n = d[1];
endfunction

function automatic logic [7:0] exp_peff7();
	return m_peff7[2] ? (m_peff7 & 8'hB1) : m_peff7;
endfunction

// video strobes of a write, {zborder, border, zvpage, vpage, vconf, palsel, tsconf}
function automatic logic [6:0] exp_vid_wr(logic [15:0] addr);
	logic [7:0] lo;
	logic [7:0] hi;
	lo = addr[7:0];
	hi = addr[15:8];
	return {lo == 8'hFE, lo == 8'hAF && hi == 8'h0F,
		lo == 8'hFD && !hi[7] && !m_p7ffd[5], lo == 8'hAF && hi == 8'h01,
		lo == 8'hAF && hi == 8'h00, lo == 8'hAF && hi == 8'h07, lo == 8'hAF && hi == 8'h06};
endfunction

// {cs0_n, cs1_n}, C8 is the control register behind cs1
function automatic logic [1:0] exp_ide_cs(logic [7:0] lo);
	if (lo == 8'hC8) return 2'b10;
	if (lo inside {8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0}) return 2'b01;
	return 2'b11;
endfunction

// device register number behind an IDE port
function automatic logic [2:0] exp_ide_reg(logic [7:0] lo);
	if (lo == 8'hC8) return 3'd6;
	return 3'((lo - 8'h10) >> 5);
endfunction

function automatic logic exp_porthit(logic [15:0] addr, logic dv);
	logic [7:0] lo;
	lo = addr[7:0];
	return lo == 8'hFE || lo == 8'hAF || lo == 8'hFD || (lo == 8'hF7 && addr[8] != dv)
		|| lo inside {8'h10, 8'h11, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0, 8'hC8}
		|| (lo == 8'h77 && !dv) || lo == 8'h57;
endfunction

// read data for every non-IDE port
function automatic logic [7:0] exp_dout(logic [15:0] addr, logic dv, logic [4:0] k,
	logic t, logic [7:0] sd);
	logic [7:0] lo;
	lo = addr[7:0];
	if (lo == 8'hFE) return {1'b1, t, 1'b0, k};
	if (lo == 8'hAF && addr[15:8] == 8'h12) return m_page[2];
	if (lo == 8'hAF && addr[15:8] == 8'h13) return m_page[3];
	if (lo == 8'h57) return sd;
	if (lo == 8'h77 && !dv) return 8'h00;
	return 8'hFF;
endfunction

`endif

//--- tb/tb_zports.sv
/* Directed IDE sequences, then random I/O cycles on the non-IDE ports against a model,
   then a free-running address decode sweep. Each I/O cycle is 4 active and 2 idle clocks. */
`timescale 1ns/1ns
`default_nettype none

module tb_zports;
	localparam int NUM_PAGES = 4;
	localparam int RAND_CYCLES = 2000;
	localparam int LIMIT = 200 + RAND_CYCLES * 6 + 500;

	logic zclk = 1'b0;
	logic rst_n;
	logic [15:0] a;
	logic [7:0] din;
	logic iord, iowr, dos, tape_read;
	logic [4:0] keys_in;
	logic [15:0] idein;
	logic [7:0] sd_dataout;
	logic [7:0] dout, sysconf, memconf, im2vect, peff7, sd_datain;
	logic dataout, porthit, idedataout, ide_cs0_n, ide_cs1_n, ide_rd_n, ide_wr_n;
	logic [15:0] ideout;
	logic [2:0] ide_a;
	logic [NUM_PAGES*8-1:0] xt_page;
	logic [4:0] fmaddr;
	logic [3:0] fddvirt;
	logic p7ffd_1m_on, p7ffd_ram0_0, romrw_en, sdcs_n, sd_start;
	xt_regs_pkg::video_wr_t vid_wr;

	logic [31:0] seed = 32'd23974;
	int cycles = 0;
	int starts;
	int vid_cnt;
	logic [6:0] vid_seen;
	logic [7:0] cap_sd_in;
	logic [7:0] rd_byte;
	logic [15:0] cap_ideout;
	logic cap_wr_n, cap_rd_n, cap_idedata, cap_porthit, cap_dataout;

	`include "tb_zports_model.svh"

	zports_top #(.NUM_PAGES(NUM_PAGES)) dut_i (.*);

	always #2 zclk = ~zclk;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return {8'h00, seed[31:8]}; // upper bits are the better ones
	endfunction

	task automatic stop_fail();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERR %s got %h exp %h", name, got, exp);
			stop_fail();
		end
	endtask

	always @(posedge zclk)
	begin
		cycles <= cycles + 1;
		if (cycles > LIMIT)
		begin
			$display("timeout: test did not finish within %0d cycles", LIMIT);
			stop_fail();
		end
	end

	// one clock of strobe watching, SPI and video strobes
	task automatic sample_strobes();
		@(negedge zclk);
		if (sd_start)
		begin
			starts++;
			cap_sd_in = sd_datain;
		end
		if (vid_wr != '0)
		begin
			vid_cnt++;
			vid_seen = vid_seen | vid_wr;
		end
	endtask

	// one Z80 I/O cycle, samples kept for the caller
	task automatic io_cycle(input logic wr, input logic [15:0] addr, input logic [7:0] data,
		input logic dv);
		logic [31:0] r;
		int i;
		r = lcg_next();
		@(posedge zclk);
		a <= addr;
		din <= data;
		dos <= dv;
		iowr <= wr;
		iord <= !wr;
		keys_in <= r[4:0];
		tape_read <= r[5];
		sd_dataout <= r[15:8];
		starts = 0;
		vid_cnt = 0;
		vid_seen = 7'h00;
		cap_sd_in = 8'h00;
		for (i = 0; i < 4; i++)
		begin
			sample_strobes();
			if (i == 1)
			begin
				cap_ideout = ideout;
				cap_wr_n = ide_wr_n;
				cap_rd_n = ide_rd_n;
				cap_idedata = idedataout;
				cap_porthit = porthit;
				cap_dataout = dataout;
			end
			if (i == 2) rd_byte = dout;
		end
		@(posedge zclk);
		iord <= 1'b0;
		iowr <= 1'b0;
		repeat (2) sample_strobes();
	endtask

	task automatic check_regs();
		check_val("xt_page", 32'(xt_page), {m_page[3], m_page[2], m_page[1], m_page[0]});
		check_val("sysconf", 32'(sysconf), 32'(m_sysconf));
		check_val("memconf", 32'(memconf), 32'(m_memconf));
		check_val("im2vect", 32'(im2vect), 32'(m_im2vect));
		check_val("fddvirt", 32'(fddvirt), 32'(m_fddvirt));
		check_val("fmaddr_en", 32'(fmaddr[4]), 32'(m_fm_hi));
		if (m_fm_known) check_val("fmaddr", 32'(fmaddr[3:0]), 32'(m_fm_lo));
		check_val("peff7", 32'(peff7), 32'(exp_peff7()));
		check_val("p7ffd_1m_on", 32'(p7ffd_1m_on), 32'(!m_peff7[2]));
		check_val("p7ffd_ram0_0", 32'(p7ffd_ram0_0), 32'(m_peff7[3]));
		check_val("romrw_en", 32'(romrw_en), 32'(m_memconf[1]));
		check_val("sdcs_n", 32'(sdcs_n), 32'(m_sdcs_n));
	endtask

	task automatic ide_tests();
		logic [31:0] r;
		logic [15:0] w;
		r = lcg_next();
		io_cycle(1'b1, 16'h0011, r[15:8], 1'b0); // normal: high then low
		io_cycle(1'b1, 16'h0010, r[7:0], 1'b0);
		check_val("ide_wr_n", 32'(cap_wr_n), 32'h0);
		check_val("idedataout", 32'(cap_idedata), 32'h1);
		check_val("ideout", 32'(cap_ideout), 32'(r[15:0]));
		io_cycle(1'b1, 16'h0010, r[23:16], 1'b0); // divide: low byte only held
		check_val("ide_wr_n", 32'(cap_wr_n), 32'h1);
		check_val("idedataout", 32'(cap_idedata), 32'h0);
		io_cycle(1'b1, 16'h0010, r[15:8], 1'b0);
		check_val("ide_wr_n", 32'(cap_wr_n), 32'h0);
		check_val("idedataout", 32'(cap_idedata), 32'h1);
		check_val("ideout", 32'(cap_ideout), {16'h0, r[15:8], r[23:16]});
		w = lcg_next();
		@(posedge zclk);
		idein <= w;
		io_cycle(1'b0, 16'h0010, 8'h00, 1'b0);
		check_val("ide_rd_n", 32'(cap_rd_n), 32'h0);
		check_val("dout", 32'(rd_byte), 32'(w[7:0]));
		io_cycle(1'b0, 16'h0011, 8'h00, 1'b0);
		check_val("dout", 32'(rd_byte), 32'(w[15:8]));
		w = lcg_next();
		@(posedge zclk);
		idein <= w;
		io_cycle(1'b0, 16'h0010, 8'h00, 1'b0); // divide read pair
		check_val("dout", 32'(rd_byte), 32'(w[7:0]));
		@(posedge zclk);
		idein <= ~w; // high byte must come from the first read
		io_cycle(1'b0, 16'h0010, 8'h00, 1'b0);
		check_val("ide_rd_n", 32'(cap_rd_n), 32'h1);
		check_val("dout", 32'(rd_byte), 32'(w[15:8]));
	endtask

	// every IDE port with the bus idle, 11 selects no device
	task automatic ide_decode_sweep();
		logic [7:0] ports [10];
		int n;
		ports = '{8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0, 8'hC8, 8'h11};
		for (n = 0; n < 10; n++)
		begin
			@(posedge zclk);
			a <= {8'h00, ports[n]};
			@(negedge zclk);
			check_val("ide_cs", 32'({ide_cs0_n, ide_cs1_n}), 32'(exp_ide_cs(ports[n])));
			if (exp_ide_cs(ports[n]) != 2'b11)
				check_val("ide_a", 32'(ide_a), 32'(exp_ide_reg(ports[n])));
		end
	endtask

	task automatic random_cycles();
		logic [7:0] ports [6];
		logic [7:0] idx [14];
		logic [31:0] r;
		logic [31:0] d;
		logic [15:0] addr;
		logic [7:0] data;
		logic [6:0] exp_vid;
		logic wr, dv;
		int n;
		ports = '{8'hFE, 8'hAF, 8'hFD, 8'hF7, 8'h77, 8'h57};
		idx = '{8'h00, 8'h01, 8'h06, 8'h07, 8'h0F, 8'h10, 8'h11, 8'h12, 8'h13,
			8'h15, 8'h20, 8'h21, 8'h25, 8'h29};
		for (n = 0; n < RAND_CYCLES; n++)
		begin
			r = lcg_next();
			d = lcg_next();
			addr = {r[15:8], ports[r[2:0] % 6]};
			if (addr[7:0] == 8'hAF && r[17:16] != 2'b00) addr[15:8] = idx[r[21:18] % 14];
			data = d[7:0];
			if (addr[7:0] == 8'hFD && r[23:20] != 4'h0) data[5] = 1'b0; // rare lock
			wr = r[3];
			dv = (r[5:4] == 2'b00);
			io_cycle(wr, addr, data, dv);
			exp_vid = wr ? exp_vid_wr(addr) : 7'h00;
			check_val("vid_wr", 32'(vid_seen), 32'(exp_vid));
			check_val("vid_wr count", 32'(vid_cnt), (exp_vid != 7'h00) ? 32'h1 : 32'h0);
			if (starts == 1)
				check_val("sd_datain", 32'(cap_sd_in), wr ? 32'(data) : 32'hFF);
			if (wr) model_write(addr, data, dv);
			else check_val("dout", 32'(rd_byte),
				32'(exp_dout(addr, dv, keys_in, tape_read, sd_dataout)));
			check_val("porthit", 32'(cap_porthit), 32'(exp_porthit(addr, dv)));
			check_val("dataout", 32'(cap_dataout), 32'(exp_porthit(addr, dv) && !wr));
			check_val("sd_start count", 32'(starts),
				(addr[7:0] == 8'h57 && !(wr && dv && addr[15])) ? 32'h1 : 32'h0);
			check_regs();
		end
	endtask

	initial
	begin
		logic [31:0] r;
		rst_n = 1'b0;
		a = 16'h0000;
		din = 8'h00;
		iord = 1'b0;
		iowr = 1'b0;
		dos = 1'b0;
		keys_in = 5'h1F;
		tape_read = 1'b0;
		idein = 16'h0000;
		sd_dataout = 8'hFF;
		model_reset();
		repeat (3) @(posedge zclk);
		rst_n <= 1'b1;
		@(negedge zclk);
		check_regs();
		check_val("ide_rd_n", 32'(ide_rd_n), 32'h1);
		check_val("ide_wr_n", 32'(ide_wr_n), 32'h1);
		ide_tests();
		ide_decode_sweep();
		random_cycles();
		repeat (150)
		begin
			r = lcg_next();
			@(posedge zclk);
			a <= r[15:0];
			dos <= r[16];
			iord <= r[17];
			@(negedge zclk);
			check_val("porthit", 32'(porthit), 32'(exp_porthit(a, dos)));
			check_val("dataout", 32'(dataout), 32'(exp_porthit(a, dos) && iord));
			check_val("ide_cs", 32'({ide_cs0_n, ide_cs1_n}), 32'(exp_ide_cs(a[7:0])));
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+tb
src/z80_bus_pkg.sv
src/xt_regs_pkg.sv
src/io_cycle_decode.sv
src/xt_config_regs.sv
src/ide_bridge.sv
src/sd_port.sv
src/port_read_mux.sv
src/zports_top.sv
tb/tb_zports.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the port block testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_zports -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	cat build.log
	exit 1
fi

./obj_dir/Vtb_zports > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
